/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall
TOP       ?= tb_i3c_target
RTL_TOP   ?= i3c_target_top
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := all tests passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Output goes to the terminal, the grep status decides the result
run: build
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep "$(PASS_MSG)" > /dev/null

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* bus_byte_io.sv */
// Bit shifter for bus bytes, ACK slots and T-bits on the open-drain SDA
module bus_byte_io (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             scl_rise_i,
  input  logic                             scl_fall_i,
  input  logic                             sda_s_i,
  input  logic                             rx_req_i,
  input  logic                             tx_req_i,
  input  logic                             tx_bit_only_i,
  input  logic [i3c_target_pkg::ByteW-1:0] tx_data_i,
  output i3c_target_pkg::rx_byte_u         rx_byte_o,
  output logic                             rx_tbit_o,
  output logic                             io_done_o,
  output logic                             sda_o
);
  import i3c_target_pkg::*;

  logic [ByteW-1:0] shift_q;
  logic [3:0]       left_q;
  logic             active_q;
  logic             tx_q;
  logic             bit_only_q;

  assign rx_byte_o.raw = shift_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      shift_q    <= '0;
      left_q     <= '0;
      active_q   <= 1'b0;
      tx_q       <= 1'b0;
      bit_only_q <= 1'b0;
      rx_tbit_o  <= 1'b0;
      io_done_o  <= 1'b0;
      sda_o      <= 1'b1;
    end else begin
      io_done_o <= 1'b0;
      if (rx_req_i || tx_req_i) begin
        // New request restarts the shifter, bit_only means a single slot
        active_q   <= 1'b1;
        tx_q       <= tx_req_i;
        bit_only_q <= tx_bit_only_i;
        left_q     <= tx_bit_only_i ? 4'd1 : 4'd8;
        if (tx_req_i) begin
          shift_q <= tx_data_i;
        end
      end else if (scl_fall_i) begin
        if (active_q && tx_q && left_q != 0) begin
          sda_o   <= shift_q[ByteW-1];
          shift_q <= shift_q << 1;
          left_q  <= left_q - 1'b1;
        end else begin
          sda_o <= 1'b1;
        end
      end else if (scl_rise_i && active_q) begin
        if (tx_q) begin
          // Last driven bit sampled, line held until the next fall
          if (left_q == 0) begin
            active_q  <= 1'b0;
            io_done_o <= 1'b1;
          end
        end else begin
          if (bit_only_q) begin
            rx_tbit_o <= sda_s_i;
          end else begin
            shift_q <= {shift_q[ByteW-2:0], sda_s_i};
          end
          left_q <= left_q - 1'b1;
          if (left_q == 4'd1) begin
            active_q  <= 1'b0;
            io_done_o <= 1'b1;
          end
        end
      end
    end
  end

endmodule

/* bus_monitor.sv */
// SCL/SDA synchronizer with SCL edge and START/STOP detection
module bus_monitor (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic scl_i,
  input  logic sda_i,
  output logic scl_rise_o,
  output logic scl_fall_o,
  output logic sda_s_o,
  output logic start_o,
  output logic stop_o
);

  // Two synchronizer stages, then the previous sample in bit 2
  logic [2:0] scl_q;
  logic [2:0] sda_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      scl_q <= '1;
      sda_q <= '1;
    end else begin
      scl_q <= {scl_q[1:0], scl_i};
      sda_q <= {sda_q[1:0], sda_i};
    end
  end

  // Registered events, three cycles after the pin
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      scl_rise_o <= 1'b0;
      scl_fall_o <= 1'b0;
      sda_s_o    <= 1'b1;
      start_o    <= 1'b0;
      stop_o     <= 1'b0;
    end else begin
      scl_rise_o <= scl_q[1] & ~scl_q[2];
      scl_fall_o <= ~scl_q[1] & scl_q[2];
      sda_s_o    <= sda_q[1];
      // SDA moving while SCL stays high
      start_o    <= scl_q[1] & scl_q[2] & ~sda_q[1] & sda_q[2];
      stop_o     <= scl_q[1] & scl_q[2] & sda_q[1] & ~sda_q[2];
    end
  end

endmodule

/* byte_fifo.sv */
// Circular byte FIFO with head output and fill level
module byte_fifo (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              push_i,
  input  logic [i3c_target_pkg::ByteW-1:0]  data_i,
  input  logic                              pop_i,
  output logic [i3c_target_pkg::ByteW-1:0]  data_o,
  output logic                              full_o,
  output logic                              empty_o,
  output logic [i3c_target_pkg::LevelW-1:0] level_o
);
  import i3c_target_pkg::*;

  logic [ByteW-1:0]             mem_q [FifoDepth];
  logic [$clog2(FifoDepth)-1:0] wr_ptr_q;
  logic [$clog2(FifoDepth)-1:0] rd_ptr_q;
  logic                         do_push;
  logic                         do_pop;

  assign full_o  = (level_o == LevelW'(FifoDepth));
  assign empty_o = (level_o == '0);
  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;
  assign data_o  = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  // Pointers wrap on their own, depth is a power of two
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      level_o  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      if (do_push != do_pop) begin
        level_o <= do_push ? level_o + 1'b1 : level_o - 1'b1;
      end
    end
  end

endmodule

/* i3c_target_pkg.sv */
// Shared constants, register map, FSM state codes and received-byte union
package i3c_target_pkg;

  localparam int unsigned ByteW     = 8;
  localparam int unsigned AddrW     = 7;
  localparam int unsigned FifoDepth = 8;
  localparam int unsigned LevelW    = 4;
  localparam int unsigned ApbAddrW  = 4;
  localparam int unsigned ApbDataW  = 32;

  // Register offsets
  localparam logic [ApbAddrW-1:0] RegCtrl   = 4'h0;
  localparam logic [ApbAddrW-1:0] RegStatus = 4'h4;
  localparam logic [ApbAddrW-1:0] RegRxData = 4'h8;
  localparam logic [ApbAddrW-1:0] RegTxData = 4'hC;

  localparam logic [AddrW-1:0] BroadcastAddr = 7'h7E;

  // Target FSM states
  localparam int unsigned StateW = 3;
  localparam logic [StateW-1:0] StIdle  = 3'd0;
  localparam logic [StateW-1:0] StHdr   = 3'd1;
  localparam logic [StateW-1:0] StAck   = 3'd2;
  localparam logic [StateW-1:0] StWData = 3'd3;
  localparam logic [StateW-1:0] StWTbit = 3'd4;
  localparam logic [StateW-1:0] StRData = 3'd5;
  localparam logic [StateW-1:0] StRTbit = 3'd6;

  // Received byte, seen as payload or as address header
  typedef union packed {
    logic [ByteW-1:0] raw;
    struct packed {
      logic [AddrW-1:0] addr;
      logic             rnw;
    } hdr;
  } rx_byte_u;

endpackage

/* i3c_target_top.sv */
// Top level of the I3C private-transfer target with its APB host port
module i3c_target_top (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic                                scl_i,
  input  logic                                sda_i,
  output logic                                sda_o,
  input  logic                                psel_i,
  input  logic                                penable_i,
  input  logic                                pwrite_i,
  input  logic [i3c_target_pkg::ApbAddrW-1:0] paddr_i,
  input  logic [i3c_target_pkg::ApbDataW-1:0] pwdata_i,
  output logic [i3c_target_pkg::ApbDataW-1:0] prdata_o,
  output logic                                pready_o,
  output logic                                pslverr_o
);
  import i3c_target_pkg::*;

  logic              scl_rise;
  logic              scl_fall;
  logic              sda_s;
  logic              start_det;
  logic              stop_det;
  logic              rx_req;
  logic              tx_req;
  logic              tx_bit_only;
  logic              tx_bit;
  logic              io_done;
  rx_byte_u          rx_byte;
  logic              rx_tbit;
  logic              rx_push;
  logic [ByteW-1:0]  rx_wdata;
  logic [ByteW-1:0]  rx_head;
  logic              rx_full;
  logic              rx_empty;
  logic [LevelW-1:0] rx_level;
  logic              rx_pop;
  logic              tx_push;
  logic [ByteW-1:0]  tx_wdata;
  logic [ByteW-1:0]  tx_head;
  logic              tx_full;
  logic              tx_empty;
  logic [LevelW-1:0] tx_level;
  logic              tx_pop;
  logic              parity_err;
  logic              rx_ovf;
  logic              hdr_evt;
  logic [ByteW-1:0]  hdr;
  logic              enable;
  logic [AddrW-1:0]  dyn_addr;

  bus_monitor u_bus_monitor (
    .clk_i,
    .rst_ni,
    .scl_i,
    .sda_i,
    .scl_rise_o (scl_rise),
    .scl_fall_o (scl_fall),
    .sda_s_o    (sda_s),
    .start_o    (start_det),
    .stop_o     (stop_det)
  );

  // Top bit carries the FSM's bit, which is the TX head bit in byte mode
  bus_byte_io u_bus_byte_io (
    .clk_i,
    .rst_ni,
    .scl_rise_i    (scl_rise),
    .scl_fall_i    (scl_fall),
    .sda_s_i       (sda_s),
    .rx_req_i      (rx_req),
    .tx_req_i      (tx_req),
    .tx_bit_only_i (tx_bit_only),
    .tx_data_i     ({tx_bit, tx_head[ByteW-2:0]}),
    .rx_byte_o     (rx_byte),
    .rx_tbit_o     (rx_tbit),
    .io_done_o     (io_done),
    .sda_o
  );

  target_fsm u_target_fsm (
    .clk_i,
    .rst_ni,
    .enable_i      (enable),
    .dyn_addr_i    (dyn_addr),
    .start_i       (start_det),
    .stop_i        (stop_det),
    .io_done_i     (io_done),
    .rx_byte_i     (rx_byte),
    .rx_tbit_i     (rx_tbit),
    .rx_full_i     (rx_full),
    .tx_empty_i    (tx_empty),
    .tx_data_i     (tx_head),
    .rx_req_o      (rx_req),
    .tx_req_o      (tx_req),
    .tx_bit_only_o (tx_bit_only),
    .tx_bit_o      (tx_bit),
    .rx_push_o     (rx_push),
    .rx_data_o     (rx_wdata),
    .tx_pop_o      (tx_pop),
    .parity_err_o  (parity_err),
    .rx_ovf_o      (rx_ovf),
    .hdr_evt_o     (hdr_evt),
    .hdr_o         (hdr)
  );

  byte_fifo u_rx_fifo (
    .clk_i,
    .rst_ni,
    .push_i  (rx_push),
    .data_i  (rx_wdata),
    .pop_i   (rx_pop),
    .data_o  (rx_head),
    .full_o  (rx_full),
    .empty_o (rx_empty),
    .level_o (rx_level)
  );

  byte_fifo u_tx_fifo (
    .clk_i,
    .rst_ni,
    .push_i  (tx_push),
    .data_i  (tx_wdata),
    .pop_i   (tx_pop),
    .data_o  (tx_head),
    .full_o  (tx_full),
    .empty_o (tx_empty),
    .level_o (tx_level)
  );

  target_regs u_target_regs (
    .clk_i,
    .rst_ni,
    .psel_i,
    .penable_i,
    .pwrite_i,
    .paddr_i,
    .pwdata_i,
    .rx_data_i    (rx_head),
    .rx_empty_i   (rx_empty),
    .rx_level_i   (rx_level),
    .tx_full_i    (tx_full),
    .tx_level_i   (tx_level),
    .parity_err_i (parity_err),
    .rx_ovf_i     (rx_ovf),
    .hdr_evt_i    (hdr_evt),
    .hdr_i        (hdr),
    .prdata_o,
    .pready_o,
    .pslverr_o,
    .enable_o     (enable),
    .dyn_addr_o   (dyn_addr),
    .rx_pop_o     (rx_pop),
    .tx_push_o    (tx_push),
    .tx_data_o    (tx_wdata)
  );

endmodule

/* list.f */
i3c_target_pkg.sv
bus_monitor.sv
bus_byte_io.sv
target_fsm.sv
byte_fifo.sv
target_regs.sv
i3c_target_top.sv
tb_i3c_target.sv

/* target_fsm.sv */
// Private transfer FSM with header match, ACK, T-bit parity and FIFO handshakes
module target_fsm (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             enable_i,
  input  logic [i3c_target_pkg::AddrW-1:0] dyn_addr_i,
  input  logic                             start_i,
  input  logic                             stop_i,
  input  logic                             io_done_i,
  input  i3c_target_pkg::rx_byte_u         rx_byte_i,
  input  logic                             rx_tbit_i,
  input  logic                             rx_full_i,
  input  logic                             tx_empty_i,
  input  logic [i3c_target_pkg::ByteW-1:0] tx_data_i,
  output logic                             rx_req_o,
  output logic                             tx_req_o,
  output logic                             tx_bit_only_o,
  output logic                             tx_bit_o,
  output logic                             rx_push_o,
  output logic [i3c_target_pkg::ByteW-1:0] rx_data_o,
  output logic                             tx_pop_o,
  output logic                             parity_err_o,
  output logic                             rx_ovf_o,
  output logic                             hdr_evt_o,
  output logic [i3c_target_pkg::ByteW-1:0] hdr_o
);
  import i3c_target_pkg::*;

  logic [StateW-1:0] state_q;
  logic [StateW-1:0] state_d;
  logic              rnw_q;
  logic              rnw_d;
  logic              more_q;
  logic              more_d;
  logic              hdr_match;
  logic              parity_ok;

  // A read header needs data waiting in the TX FIFO
  assign hdr_match = enable_i && (rx_byte_i.hdr.addr == dyn_addr_i) &&
                     (rx_byte_i.hdr.addr != BroadcastAddr) &&
                     !(rx_byte_i.hdr.rnw && tx_empty_i);
  assign parity_ok = ^{rx_byte_i.raw, rx_tbit_i};
  assign rx_data_o = rx_byte_i.raw;
  assign hdr_o     = rx_byte_i.raw;

  always_comb begin
    state_d       = state_q;
    rnw_d         = rnw_q;
    more_d        = more_q;
    rx_req_o      = 1'b0;
    tx_req_o      = 1'b0;
    tx_bit_only_o = 1'b0;
    tx_bit_o      = tx_data_i[ByteW-1];
    rx_push_o     = 1'b0;
    tx_pop_o      = 1'b0;
    parity_err_o  = 1'b0;
    rx_ovf_o      = 1'b0;
    hdr_evt_o     = 1'b0;
    if (start_i) begin
      rx_req_o = 1'b1;
      state_d  = StHdr;
    end else if (stop_i) begin
      state_d = StIdle;
    end else if (io_done_i) begin
      case (state_q)
        StHdr: begin
          // No match leaves SDA released in the ACK slot
          if (hdr_match) begin
            tx_req_o      = 1'b1;
            tx_bit_only_o = 1'b1;
            tx_bit_o      = 1'b0;
            hdr_evt_o     = 1'b1;
            rnw_d         = rx_byte_i.hdr.rnw;
            state_d       = StAck;
          end else begin
            state_d = StIdle;
          end
        end
        StAck, StRTbit: begin
          if (state_q == StAck && !rnw_q) begin
            rx_req_o = 1'b1;
            state_d  = StWData;
          end else if (state_q == StAck || more_q) begin
            tx_req_o = 1'b1;
            tx_pop_o = 1'b1;
            state_d  = StRData;
          end else begin
            state_d = StIdle;
          end
        end
        StRData: begin
          // T-bit high while more data is queued
          more_d        = !tx_empty_i;
          tx_req_o      = 1'b1;
          tx_bit_only_o = 1'b1;
          tx_bit_o      = !tx_empty_i;
          state_d       = StRTbit;
        end
        StWData: begin
          rx_req_o      = 1'b1;
          tx_bit_only_o = 1'b1;
          state_d       = StWTbit;
        end
        StWTbit: begin
          if (!parity_ok) begin
            parity_err_o = 1'b1;
          end else if (rx_full_i) begin
            rx_ovf_o = 1'b1;
          end else begin
            rx_push_o = 1'b1;
          end
          rx_req_o = 1'b1;
          state_d  = StWData;
        end
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= StIdle;
      rnw_q   <= 1'b0;
      more_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      rnw_q   <= rnw_d;
      more_q  <= more_d;
    end
  end

endmodule

/* target_regs.sv */
// APB registers for control, status, sticky errors and the FIFO data ports
module target_regs (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic                                psel_i,
  input  logic                                penable_i,
  input  logic                                pwrite_i,
  input  logic [i3c_target_pkg::ApbAddrW-1:0] paddr_i,
  input  logic [i3c_target_pkg::ApbDataW-1:0] pwdata_i,
  input  logic [i3c_target_pkg::ByteW-1:0]    rx_data_i,
  input  logic                                rx_empty_i,
  input  logic [i3c_target_pkg::LevelW-1:0]   rx_level_i,
  input  logic                                tx_full_i,
  input  logic [i3c_target_pkg::LevelW-1:0]   tx_level_i,
  input  logic                                parity_err_i,
  input  logic                                rx_ovf_i,
  input  logic                                hdr_evt_i,
  input  logic [i3c_target_pkg::ByteW-1:0]    hdr_i,
  output logic [i3c_target_pkg::ApbDataW-1:0] prdata_o,
  output logic                                pready_o,
  output logic                                pslverr_o,
  output logic                                enable_o,
  output logic [i3c_target_pkg::AddrW-1:0]    dyn_addr_o,
  output logic                                rx_pop_o,
  output logic                                tx_push_o,
  output logic [i3c_target_pkg::ByteW-1:0]    tx_data_o
);
  import i3c_target_pkg::*;

  logic             access;
  logic             wr_en;
  logic             addr_ok;
  logic [2:0]       err_q;
  logic [2:0]       err_set;
  logic [2:0]       err_clr;
  logic [ByteW-1:0] hdr_q;

  assign access    = psel_i && penable_i;
  assign wr_en     = access && pwrite_i;
  assign addr_ok   = paddr_i inside {RegCtrl, RegStatus, RegRxData, RegTxData};
  assign pready_o  = access;
  assign pslverr_o = access && !addr_ok;
  assign rx_pop_o  = access && !pwrite_i && (paddr_i == RegRxData);
  assign tx_push_o = wr_en && (paddr_i == RegTxData);
  assign tx_data_o = pwdata_i[ByteW-1:0];

  // Error bits in STATUS order: tx_ovf, rx_ovf, parity_err
  assign err_set = {tx_push_o && tx_full_i, rx_ovf_i, parity_err_i};
  assign err_clr = (wr_en && paddr_i == RegStatus) ? pwdata_i[10:8] : 3'b000;

  always_comb begin
    case (paddr_i)
      RegCtrl:   prdata_o = ApbDataW'({dyn_addr_o, enable_o});
      RegStatus: prdata_o = ApbDataW'({hdr_q, 5'b00000, err_q, tx_level_i, rx_level_i});
      RegRxData: prdata_o = rx_empty_i ? '0 : ApbDataW'(rx_data_i);
      default:   prdata_o = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      enable_o   <= 1'b0;
      dyn_addr_o <= '0;
      err_q      <= '0;
      hdr_q      <= '0;
    end else begin
      if (wr_en && paddr_i == RegCtrl) begin
        enable_o   <= pwdata_i[0];
        dyn_addr_o <= pwdata_i[AddrW:1];
      end
      // New events win over a clear in the same cycle
      err_q <= (err_q & ~err_clr) | err_set;
      if (hdr_evt_i) begin
        hdr_q <= hdr_i;
      end
    end
  end

endmodule

/* tb_i3c_target.sv */
// Testbench for the I3C target with bus controller model, APB host tasks, tests and watchdog
module tb_i3c_target;
  timeunit 1ns;
  timeprecision 100ps;
  import i3c_target_pkg::*;

  localparam int ClkPeriod    = 40;
  localparam int ResetCycles  = 16;
  localparam int HalfCyc      = 10;
  localparam int ByteCycles   = 9 * 2 * HalfCyc;
  localparam int XferOverhead = 3 * HalfCyc;
  localparam int ApbCycles    = 3;
  // Test lengths in clock cycles derived from transfers, bytes and APB accesses
  localparam int Test1Cycles  = 4 * ApbCycles;
  localparam int Test2Cycles  = 3 * (XferOverhead + 2 * ByteCycles) + 5 * ApbCycles;
  localparam int Test3Cycles  = XferOverhead + 6 * ByteCycles + 6 * ApbCycles;
  localparam int Test4Cycles  = 2 * XferOverhead + 12 * ByteCycles + 12 * ApbCycles;
  localparam int Test5Cycles  = 2 * XferOverhead + 5 * ByteCycles + 4 * ApbCycles;
  localparam int WatchdogCycles = 2 * (ResetCycles + Test1Cycles + Test2Cycles +
                                       Test3Cycles + Test4Cycles + Test5Cycles);
  localparam logic [AddrW-1:0] TgtAddr = 7'h2A;

  logic                clk;
  logic                rst_n;
  logic                scl;
  logic                sda_ctrl;
  logic                sda_dut;
  wire                 sda_bus;
  logic                psel;
  logic                penable;
  logic                pwrite;
  logic [ApbAddrW-1:0] paddr;
  logic [ApbDataW-1:0] pwdata;
  logic [ApbDataW-1:0] prdata;
  logic                pready;
  logic                pslverr;
  int                  seed = 79854;
  int                  checks = 0;
  int                  errors = 0;

  // Open-drain line where either side pulls low
  assign sda_bus = sda_ctrl & sda_dut;

  i3c_target_top i3c_target_top_i (
    .clk_i     (clk),
    .rst_ni    (rst_n),
    .scl_i     (scl),
    .sda_i     (sda_bus),
    .sda_o     (sda_dut),
    .psel_i    (psel),
    .penable_i (penable),
    .pwrite_i  (pwrite),
    .paddr_i   (paddr),
    .pwdata_i  (pwdata),
    .prdata_o  (prdata),
    .pready_o  (pready),
    .pslverr_o (pslverr)
  );

  initial begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  task automatic wait_cycles(input int n);
    repeat (n) @(negedge clk);
  endtask

  task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("Mismatch at %0t ns: %s, got 0x%0h, expected 0x%0h", $time, what, got, exp);
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    checks++;
    assert (cond === 1'b1) else begin
      errors++;
      $display("Error at %0t ns: %s", $time, what);
    end
  endtask

  task automatic report_test(input string name, input int errors_before);
    $display("%s: %s, %0d errors", name, (errors == errors_before) ? "ok" : "FAILED",
             errors - errors_before);
  endtask

  // Odd parity over data byte and T-bit
  function automatic logic odd_tbit(input logic [7:0] b);
    return ~(^b);
  endfunction

  task automatic apb_access(input logic wr, input logic [ApbAddrW-1:0] addr,
                            input logic [ApbDataW-1:0] wdata,
                            output logic [ApbDataW-1:0] rdata, output logic err);
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(negedge clk);
    penable = 1'b1;
    #(ClkPeriod / 4);
    rdata = prdata;
    err   = pslverr;
    check_true(pready, "pready low in APB access phase");
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_write(input logic [ApbAddrW-1:0] addr, input logic [ApbDataW-1:0] data);
    logic [ApbDataW-1:0] rd;
    logic                err;
    apb_access(1'b1, addr, data, rd, err);
    check_eq("pslverr on APB write", err, 0);
  endtask

  task automatic apb_read(input logic [ApbAddrW-1:0] addr, output logic [ApbDataW-1:0] data);
    logic err;
    apb_access(1'b0, addr, '0, data, err);
    check_eq("pslverr on APB read", err, 0);
  endtask

  task automatic bus_start;
    sda_ctrl = 1'b0;
    wait_cycles(HalfCyc);
    scl = 1'b0;
  endtask

  task automatic bus_stop;
    wait_cycles(HalfCyc / 2);
    sda_ctrl = 1'b0;
    wait_cycles(HalfCyc / 2);
    scl = 1'b1;
    wait_cycles(HalfCyc);
    sda_ctrl = 1'b1;
    wait_cycles(HalfCyc);
  endtask

  // One SCL period with SDA set mid-low and sampled mid-high
  task automatic bus_bit(input logic b, output logic s);
    wait_cycles(HalfCyc / 2);
    sda_ctrl = b;
    wait_cycles(HalfCyc / 2);
    scl = 1'b1;
    wait_cycles(HalfCyc / 2);
    s = sda_bus;
    wait_cycles(HalfCyc / 2);
    scl = 1'b0;
  endtask

  task automatic write_byte(input logic [7:0] data, input logic ninth, output logic slot);
    logic s;
    for (int i = 7; i >= 0; i--) begin
      bus_bit(data[i], s);
    end
    bus_bit(ninth, slot);
  endtask

  // Random payload byte with a correct T-bit
  task automatic write_random_byte;
    logic [7:0] b;
    logic       s;
    b = 8'($random(seed));
    write_byte(b, odd_tbit(b), s);
  endtask

  task automatic read_byte(output logic [7:0] data, output logic tbit);
    logic s;
    for (int i = 7; i >= 0; i--) begin
      bus_bit(1'b1, s);
      data[i] = s;
    end
    bus_bit(1'b1, tbit);
  endtask

  // Slot value 0 means ACK
  task automatic send_header(input logic [AddrW-1:0] addr, input logic rnw, output logic slot);
    bus_start();
    write_byte({addr, rnw}, 1'b1, slot);
  endtask

  task automatic test_reset_regs;
    logic [31:0] rd;
    logic        err;
    int          e0;
    e0 = errors;
    apb_read(RegStatus, rd);
    check_eq("STATUS after reset", rd, 0);
    apb_write(RegCtrl, 32'h55);
    apb_read(RegCtrl, rd);
    check_eq("CTRL readback", rd, 32'h55);
    apb_access(1'b0, 4'h2, '0, rd, err);
    check_eq("pslverr on offset 0x2", err, 1);
    report_test("reset_regs", e0);
  endtask

  task automatic test_addressing;
    logic [31:0] rd;
    logic        slot;
    int          e0;
    e0 = errors;
    send_header(7'h2B, 1'b0, slot);
    check_eq("ACK slot for address 0x2B", slot, 1);
    write_random_byte();
    bus_stop();
    // Broadcast header NACKed even when it equals the dynamic address
    apb_write(RegCtrl, 32'hFD);
    send_header(7'h7E, 1'b0, slot);
    check_eq("ACK slot for broadcast address", slot, 1);
    write_random_byte();
    bus_stop();
    apb_write(RegCtrl, 32'h54);
    send_header(TgtAddr, 1'b0, slot);
    check_eq("ACK slot while disabled", slot, 1);
    write_random_byte();
    bus_stop();
    apb_write(RegCtrl, 32'h55);
    apb_read(RegStatus, rd);
    check_eq("RX level after NACKed headers", rd[3:0], 0);
    report_test("addressing", e0);
  endtask

  task automatic test_private_write;
    logic [7:0]  sent [5];
    logic [31:0] rd;
    logic        slot;
    int          e0;
    e0 = errors;
    send_header(TgtAddr, 1'b0, slot);
    check_eq("ACK slot for write header", slot, 0);
    for (int i = 0; i < 5; i++) begin
      sent[i] = 8'($random(seed));
      write_byte(sent[i], odd_tbit(sent[i]), slot);
    end
    bus_stop();
    for (int i = 0; i < 5; i++) begin
      apb_read(RegRxData, rd);
      check_eq("RX_DATA byte", rd, {24'h0, sent[i]});
    end
    apb_read(RegStatus, rd);
    check_eq("STATUS last header", rd[23:16], 8'h54);
    report_test("private_write", e0);
  endtask

  task automatic test_parity_overflow;
    logic [7:0]  sent [9];
    logic [7:0]  bad;
    logic [31:0] rd;
    logic        slot;
    int          e0;
    e0 = errors;
    bad = 8'($random(seed));
    send_header(TgtAddr, 1'b0, slot);
    write_byte(bad, ~odd_tbit(bad), slot);
    bus_stop();
    apb_read(RegStatus, rd);
    check_eq("parity_err after bad T-bit", rd[8], 1);
    check_eq("RX level after bad T-bit", rd[3:0], 0);
    send_header(TgtAddr, 1'b0, slot);
    for (int i = 0; i < 9; i++) begin
      sent[i] = 8'($random(seed));
      write_byte(sent[i], odd_tbit(sent[i]), slot);
    end
    bus_stop();
    apb_read(RegStatus, rd);
    check_eq("RX level after nine bytes", rd[3:0], 8);
    check_eq("rx_ovf after nine bytes", rd[9], 1);
    apb_write(RegStatus, 32'h700);
    apb_read(RegStatus, rd);
    check_eq("error flags after clear", rd[10:8], 0);
    // Ninth byte was dropped
    for (int i = 0; i < 8; i++) begin
      apb_read(RegRxData, rd);
      check_eq("RX_DATA byte before overflow", rd, {24'h0, sent[i]});
    end
    report_test("parity_overflow", e0);
  endtask

  task automatic test_private_read;
    logic [7:0] tx [3];
    logic [7:0] data;
    logic       tbit;
    logic       slot;
    int         e0;
    e0 = errors;
    for (int i = 0; i < 3; i++) begin
      tx[i] = 8'($random(seed));
      apb_write(RegTxData, {24'h0, tx[i]});
    end
    send_header(TgtAddr, 1'b1, slot);
    check_eq("ACK slot for read header", slot, 0);
    for (int i = 0; i < 3; i++) begin
      read_byte(data, tbit);
      check_eq("read data byte", data, tx[i]);
      check_eq("read T-bit", tbit, (i < 2) ? 1 : 0);
    end
    bus_stop();
    send_header(TgtAddr, 1'b1, slot);
    check_eq("ACK slot for read with empty TX FIFO", slot, 1);
    bus_stop();
    report_test("private_read", e0);
  endtask

  initial begin
    rst_n    = 1'b0;
    scl      = 1'b1;
    sda_ctrl = 1'b1;
    psel     = 1'b0;
    penable  = 1'b0;
    pwrite   = 1'b0;
    paddr    = '0;
    pwdata   = '0;
    wait_cycles(ResetCycles);
    rst_n = 1'b1;
    wait_cycles(2);
    test_reset_regs();
    test_addressing();
    test_private_write();
    test_parity_overflow();
    test_private_read();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  initial begin
    repeat (WatchdogCycles) @(posedge clk);
    $display("Error: watchdog expired after %0d cycles, a test did not finish", WatchdogCycles);
    $display("tests failed");
    $finish;
  end

endmodule
